// File: hdl/scope_bus_pkg.sv
// system bus types and register map for the scope subsystem
// one request cycle per access, response follows one cycle later
`default_nettype none

package scope_bus_pkg;

  // byte address width, covers 0x00..0x7f
  localparam int unsigned BAW = 7;

  // request, single cycle, wen and ren never together
  typedef struct packed {
    logic           wen;
    logic           ren;
    logic [BAW-1:0] addr;
    logic [32-1:0]  wdata;
  } bus_req_t;

  // response, rdata valid with ack
  typedef struct packed {
    logic          ack;
    logic          err;
    logic [32-1:0] rdata;
  } bus_rsp_t;

  ////////////////////
  // register map
  ////////////////////

  // acquisition control and mode
  localparam logic [BAW-1:0] ADR_CTL     = 7'h00;
  localparam logic [BAW-1:0] ADR_MODE    = 7'h04;
  // event masks
  localparam logic [BAW-1:0] ADR_STR     = 7'h10;
  localparam logic [BAW-1:0] ADR_STP     = 7'h14;
  localparam logic [BAW-1:0] ADR_TRG     = 7'h18;
  // pre/post lengths and their status counters
  localparam logic [BAW-1:0] ADR_PRE     = 7'h20;
  localparam logic [BAW-1:0] ADR_PST     = 7'h24;
  localparam logic [BAW-1:0] ADR_STS_PRE = 7'h28;
  localparam logic [BAW-1:0] ADR_STS_PST = 7'h2C;
  // level trigger
  localparam logic [BAW-1:0] ADR_POS     = 7'h30;
  localparam logic [BAW-1:0] ADR_NEG     = 7'h34;
  localparam logic [BAW-1:0] ADR_EDG     = 7'h38;
  // decimation
  localparam logic [BAW-1:0] ADR_DEC     = 7'h40;
  localparam logic [BAW-1:0] ADR_SHR     = 7'h44;
  localparam logic [BAW-1:0] ADR_AVG     = 7'h48;

endpackage

`default_nettype wire

// File: hdl/scope_stream_pkg.sv
// sample stream and block configuration types
// one signed channel, strobe handshake only, no back-pressure
`default_nettype none

package scope_stream_pkg;

  localparam int unsigned DW  = 16;  // sample width
  localparam int unsigned CW  = 16;  // acquisition counters
  localparam int unsigned DCW = 8;   // decimation counter
  localparam int unsigned DSW = 4;   // average shift
  localparam int unsigned EW  = 4;   // event vector

  // event vector bit positions
  localparam int unsigned EVN_SW   = 0;
  localparam int unsigned EVN_EDGE = 1;
  localparam int unsigned EVN_EXT0 = 2;
  localparam int unsigned EVN_EXT1 = 3;

  // one sample, dat only meaningful with vld
  typedef struct packed {
    logic                 vld;
    logic                 lst;
    logic signed [DW-1:0] dat;
  } smp_t;

  ////////////////////
  // configuration
  ////////////////////

  typedef struct packed {
    logic           avg;  // average instead of keep-one
    logic [DCW-1:0] dec;  // group size minus one
    logic [DSW-1:0] shr;  // arithmetic shift of the sum
  } dec_cfg_t;

  typedef struct packed {
    logic                 edg;  // 0 rising, 1 falling
    logic signed [DW-1:0] pos;
    logic signed [DW-1:0] neg;
  } trg_cfg_t;

  typedef struct packed {
    logic          con;  // restart after last
    logic          aut;  // trigger on pre count
    logic [EW-1:0] str;
    logic [EW-1:0] stp;
    logic [EW-1:0] trg;
    logic [CW-1:0] pre;
    logic [CW-1:0] pst;
  } acq_cfg_t;

  // single cycle strobes from software
  typedef struct packed {
    logic rst;
    logic str;
    logic stp;
    logic trg;
  } acq_ctl_t;

  typedef struct packed {
    logic          str;
    logic          stp;
    logic          trg;
    logic [CW-1:0] cnt_pre;
    logic [CW-1:0] cnt_pst;
  } acq_sts_t;

endpackage

`default_nettype wire

// File: hdl/scope_regs.sv
// register file on the system bus
// ack and rdata one cycle after the request, err always 0
// ctl bits 0..3 are strobes, they read back as status instead
`timescale 1ns/10ps
`default_nettype none

module scope_regs
  import scope_bus_pkg::*;
  import scope_stream_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  output dec_cfg_t dec_cfg,
  output trg_cfg_t trg_cfg,
  output acq_cfg_t acq_cfg,
  output acq_ctl_t acq_ctl,
  input  acq_sts_t acq_sts
);

  logic          rsp_ack;
  logic [32-1:0] rsp_rdata;
  logic          ctl_wen;

  assign ctl_wen = bus_req.wen && (bus_req.addr == ADR_CTL);

  ////////////////////
  // write decode
  ////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      dec_cfg <= '0;
      trg_cfg <= '0;
      acq_cfg <= '0;
    end else if (bus_req.wen) begin
      case (bus_req.addr)
        ADR_MODE: begin
          acq_cfg.con <= bus_req.wdata[0];
          acq_cfg.aut <= bus_req.wdata[1];
        end
        ADR_STR: acq_cfg.str <= bus_req.wdata[EW-1:0];
        ADR_STP: acq_cfg.stp <= bus_req.wdata[EW-1:0];
        ADR_TRG: acq_cfg.trg <= bus_req.wdata[EW-1:0];
        ADR_PRE: acq_cfg.pre <= bus_req.wdata[CW-1:0];
        ADR_PST: acq_cfg.pst <= bus_req.wdata[CW-1:0];
        ADR_POS: trg_cfg.pos <= bus_req.wdata[DW-1:0];
        ADR_NEG: trg_cfg.neg <= bus_req.wdata[DW-1:0];
        ADR_EDG: trg_cfg.edg <= bus_req.wdata[0];
        ADR_DEC: dec_cfg.dec <= bus_req.wdata[DCW-1:0];
        ADR_SHR: dec_cfg.shr <= bus_req.wdata[DSW-1:0];
        ADR_AVG: dec_cfg.avg <= bus_req.wdata[0];
        // status counters and unmapped words ignore writes
        default: ;
      endcase
    end
  end

  // ctl strobes, high only in the cycle after the write
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      acq_ctl <= '0;
    end else if (ctl_wen) begin
      acq_ctl <= '{rst: bus_req.wdata[0], str: bus_req.wdata[1],
                   stp: bus_req.wdata[2], trg: bus_req.wdata[3]};
    end else begin
      acq_ctl <= '0;
    end
  end

  ////////////////////
  // read and response
  ////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      rsp_ack <= 1'b0;
    end else begin
      rsp_ack <= bus_req.wen || bus_req.ren;
    end
  end

  always_ff @(posedge bus) begin
    if (bus_req.ren) begin
      case (bus_req.addr)
        ADR_CTL:     rsp_rdata <= {28'd0, acq_sts.trg, acq_sts.stp, acq_sts.str, 1'b0};
        ADR_MODE:    rsp_rdata <= {30'd0, acq_cfg.aut, acq_cfg.con};
        ADR_STR:     rsp_rdata <= {{(32-EW){1'b0}}, acq_cfg.str};
        ADR_STP:     rsp_rdata <= {{(32-EW){1'b0}}, acq_cfg.stp};
        ADR_TRG:     rsp_rdata <= {{(32-EW){1'b0}}, acq_cfg.trg};
        ADR_PRE:     rsp_rdata <= {{(32-CW){1'b0}}, acq_cfg.pre};
        ADR_PST:     rsp_rdata <= {{(32-CW){1'b0}}, acq_cfg.pst};
        ADR_STS_PRE: rsp_rdata <= {{(32-CW){1'b0}}, acq_sts.cnt_pre};
        ADR_STS_PST: rsp_rdata <= {{(32-CW){1'b0}}, acq_sts.cnt_pst};
        // levels zero extended, not sign extended
        ADR_POS:     rsp_rdata <= {{(32-DW){1'b0}}, trg_cfg.pos};
        ADR_NEG:     rsp_rdata <= {{(32-DW){1'b0}}, trg_cfg.neg};
        ADR_EDG:     rsp_rdata <= {31'd0, trg_cfg.edg};
        ADR_DEC:     rsp_rdata <= {{(32-DCW){1'b0}}, dec_cfg.dec};
        ADR_SHR:     rsp_rdata <= {{(32-DSW){1'b0}}, dec_cfg.shr};
        ADR_AVG:     rsp_rdata <= {31'd0, dec_cfg.avg};
        default:     rsp_rdata <= '0;
      endcase
    end
  end

  assign bus_rsp = '{ack: rsp_ack, err: 1'b0, rdata: rsp_rdata};

  // master never reads and writes in the same cycle
  a_req_excl: assert property (@(posedge bus) disable iff (!rst_n)
    !(bus_req.wen && bus_req.ren));

endmodule

`default_nettype wire

// File: hdl/scope_decimator.sv
// decimator, one output per group of dec+1 valid samples
// average mode sums the group, shifts right by shr, keeps the low DW bits
`timescale 1ns/10ps
`default_nettype none

module scope_decimator
  import scope_stream_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     ctl_rst,
  input  dec_cfg_t cfg,
  input  smp_t     sti,
  output smp_t     sto
);

  // worst case sum of 2**DCW samples
  localparam int unsigned AW = DW + DCW;

  logic        [DCW-1:0] cnt;
  logic signed [AW-1:0]  sum;
  logic signed [AW-1:0]  smp_ext;
  logic signed [AW-1:0]  sum_nxt;
  logic signed [AW-1:0]  avg;
  logic                  grp_end;

  logic                  out_vld;
  logic                  out_lst;
  logic signed [DW-1:0]  out_dat;

  // sign extended input
  assign smp_ext = sti.dat;
  assign sum_nxt = sum + smp_ext;
  assign avg     = sum_nxt >>> cfg.shr;
  // >= so a smaller dec written mid group still closes it
  assign grp_end = sti.vld && (cnt >= cfg.dec);

  ////////////////////
  // group counter and sum
  ////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      cnt <= '0;
      sum <= '0;
    end else if (sti.vld) begin
      if (grp_end) begin
        cnt <= '0;
        sum <= '0;
      end else begin
        cnt <= cnt + 1'b1;
        sum <= sum_nxt;
      end
    end
  end

  // output strobe
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
      out_lst <= 1'b0;
    end else begin
      out_vld <= grp_end;
      out_lst <= grp_end && sti.lst;
    end
  end

  // payload, keep-one takes the closing sample
  always_ff @(posedge bus) begin
    if (grp_end) begin
      out_dat <= cfg.avg ? avg[DW-1:0] : sti.dat;
    end
  end

  assign sto = '{vld: out_vld, lst: out_lst, dat: out_dat};

endmodule

`default_nettype wire

// File: hdl/scope_trigger.sv
// level trigger with hysteresis, samples delayed by one cycle
// edge strobe lines up with the delayed sample
`timescale 1ns/10ps
`default_nettype none

module scope_trigger
  import scope_stream_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     ctl_rst,
  input  trg_cfg_t cfg,
  input  smp_t     sti,
  output smp_t     sto,
  output logic     evn_edg
);

  logic armed;
  logic arm_hit;
  logic fire_hit;
  logic fire;

  // rising arms low and fires high, falling mirrors it
  always_comb begin
    if (!cfg.edg) begin
      arm_hit  = (sti.dat <= cfg.neg);
      fire_hit = (sti.dat >= cfg.pos);
    end else begin
      arm_hit  = (sti.dat >= cfg.pos);
      fire_hit = (sti.dat <= cfg.neg);
    end
  end

  assign fire = sti.vld && armed && fire_hit;

  // fire wins over re-arming on the same sample
  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      armed <= 1'b0;
    end else if (sti.vld) begin
      if (fire) begin
        armed <= 1'b0;
      end else if (arm_hit) begin
        armed <= 1'b1;
      end
    end
  end

  ////////////////////
  // delay stage
  ////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      sto.vld <= 1'b0;
      sto.lst <= 1'b0;
      evn_edg <= 1'b0;
    end else begin
      sto.vld <= sti.vld;
      sto.lst <= sti.vld && sti.lst;
      evn_edg <= fire;
    end
  end

  always_ff @(posedge bus) begin
    sto.dat <= sti.dat;
  end

endmodule

`default_nettype wire

// File: hdl/scope_acq.sv
// acquisition controller, pre and post trigger counting
// samples pass only while acquiring, one cycle of delay
// counters hold their final values after the run ends
`timescale 1ns/10ps
`default_nettype none

module scope_acq
  import scope_stream_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  acq_cfg_t cfg,
  input  acq_ctl_t ctl,
  input  logic     evn_edg,
  input  logic [1:0] evn_ext,
  output acq_sts_t sts,
  input  smp_t     sti,
  output smp_t     sto,
  output logic     evn_lst
);

  typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_PST} state_t;

  state_t        state;
  logic [CW-1:0] cnt_pre;
  logic [CW-1:0] cnt_pst;
  logic          sts_trg;
  logic          sts_stp;
  logic [EW-1:0] evn_hw;
  logic          do_str;
  logic          do_stp;
  logic          do_trg;
  logic          trg_ok;
  logic          pst_end;
  logic          lst_hit;

  // masked event vector, sw slot differs per use
  function automatic logic evn_hit(input logic sw, input logic [EW-1:0] hw,
                                   input logic [EW-1:0] msk);
    logic [EW-1:0] vec;
    vec         = hw;
    vec[EVN_SW] = sw;
    return |(vec & msk);
  endfunction

  always_comb begin
    evn_hw           = '0;
    evn_hw[EVN_EDGE] = evn_edg;
    evn_hw[EVN_EXT0] = evn_ext[0];
    evn_hw[EVN_EXT1] = evn_ext[1];
  end

  assign do_str  = evn_hit(ctl.str, evn_hw, cfg.str);
  assign do_stp  = evn_hit(ctl.stp, evn_hw, cfg.stp);
  assign do_trg  = evn_hit(ctl.trg, evn_hw, cfg.trg);
  // early triggers dropped until pre samples are in
  assign trg_ok  = (cnt_pre >= cfg.pre) && (do_trg || cfg.aut);
  assign pst_end = sti.vld && (state == ST_PST) && (cnt_pst + 1'b1 >= cfg.pst);
  assign lst_hit = pst_end && !do_stp && !ctl.rst;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl.rst) begin
      state   <= ST_IDLE;
      cnt_pre <= '0;
      cnt_pst <= '0;
      sts_trg <= 1'b0;
      sts_stp <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (do_str) begin
          state   <= ST_PRE;
          cnt_pre <= '0;
          cnt_pst <= '0;
          sts_trg <= 1'b0;
          sts_stp <= 1'b0;
        end
        ST_PRE: begin
          // saturate at all ones
          if (sti.vld && (cnt_pre != '1)) cnt_pre <= cnt_pre + 1'b1;
          if (trg_ok) begin
            state   <= ST_PST;
            sts_trg <= 1'b1;
          end
        end
        ST_PST: begin
          if (sti.vld) cnt_pst <= cnt_pst + 1'b1;
          if (pst_end) begin
            if (cfg.con) begin
              state   <= ST_PRE;
              cnt_pre <= '0;
              cnt_pst <= '0;
              sts_trg <= 1'b0;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
      // stop overrides everything but reset
      if (do_stp && (state != ST_IDLE)) begin
        state   <= ST_IDLE;
        sts_stp <= 1'b1;
      end
    end
  end

  assign sts = '{str: (state != ST_IDLE), stp: sts_stp, trg: sts_trg,
                 cnt_pre: cnt_pre, cnt_pst: cnt_pst};

  // output stage
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      sto.vld <= 1'b0;
      sto.lst <= 1'b0;
      evn_lst <= 1'b0;
    end else begin
      sto.vld <= sti.vld && (state != ST_IDLE) && !ctl.rst;
      sto.lst <= lst_hit;
      evn_lst <= lst_hit;
    end
  end

  always_ff @(posedge bus) begin
    sto.dat <= sti.dat;
  end

  a_lst_vld: assert property (@(posedge bus) disable iff (!rst_n) evn_lst |-> sto.vld);

endmodule

`default_nettype wire

// File: hdl/scope_top.sv
// one channel acquisition path, bus registers on the same clock
// smp_out trails the group closing input by 3 cycles
`timescale 1ns/10ps
`default_nettype none

module scope_top
  import scope_bus_pkg::*;
  import scope_stream_pkg::*;
(
  input  logic       bus,
  input  logic       rst_n,
  input  bus_req_t   bus_req,
  output bus_rsp_t   bus_rsp,
  input  smp_t       smp_in,
  input  logic [1:0] evn_ext,
  output smp_t       smp_out,
  output logic       evn_lst
);

  dec_cfg_t dec_cfg;
  trg_cfg_t trg_cfg;
  acq_cfg_t acq_cfg;
  acq_ctl_t acq_ctl;
  acq_sts_t acq_sts;
  // stream between stages
  smp_t     smp_dec;
  smp_t     smp_trg;
  logic     evn_edg;

  scope_regs regs_i (.bus(bus), .rst_n(rst_n), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .dec_cfg(dec_cfg), .trg_cfg(trg_cfg), .acq_cfg(acq_cfg), .acq_ctl(acq_ctl),
    .acq_sts(acq_sts));

  scope_decimator dec_i (.bus(bus), .rst_n(rst_n), .ctl_rst(acq_ctl.rst),
    .cfg(dec_cfg), .sti(smp_in), .sto(smp_dec));

  // trigger monitors the decimated stream
  scope_trigger trg_i (.bus(bus), .rst_n(rst_n), .ctl_rst(acq_ctl.rst),
    .cfg(trg_cfg), .sti(smp_dec), .sto(smp_trg), .evn_edg(evn_edg));

  scope_acq acq_i (.bus(bus), .rst_n(rst_n), .cfg(acq_cfg), .ctl(acq_ctl),
    .evn_edg(evn_edg), .evn_ext(evn_ext), .sts(acq_sts), .sti(smp_trg),
    .sto(smp_out), .evn_lst(evn_lst));

endmodule

`default_nettype wire

// File: test/scope_tb.sv
// testbench for scope_top, stimulus and expected counts come from test/scope_vectors.txt
// decimated sample values come from a behavioral model, the first mismatch stops the run
`timescale 1ns/10ps
`default_nettype none

module scope_tb
  import scope_bus_pkg::*;
  import scope_stream_pkg::*;
();

  logic                 bus;
  logic                 rst_n;
  bus_req_t             bus_req;
  bus_rsp_t             bus_rsp;
  smp_t                 smp_in;
  smp_t                 smp_out;
  logic [1:0]           evn_ext;
  logic                 evn_lst;
  string                tname;
  logic signed [DW-1:0] out_q[$];
  int                   lst_cnt;

  scope_top scope_top_i (.bus(bus), .rst_n(rst_n), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .smp_in(smp_in), .evn_ext(evn_ext), .smp_out(smp_out), .evn_lst(evn_lst));

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s %s expected %h actual %h", tname, what, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v ^= v << 13;
    v ^= v >> 17;
    v ^= v << 5;
    return v;
  endfunction

  // one request cycle, then wait for ack
  task automatic bus_access(input logic wr, input logic [BAW-1:0] a, input logic [31:0] d,
                            output logic [31:0] rd);
    int n;
    @(posedge bus);
    bus_req <= '{wen: wr, ren: !wr, addr: a, wdata: d};
    @(posedge bus);
    bus_req <= '0;
    n = 0;
    do begin
      @(posedge bus);
      n++;
      if (n > 20) abort_run("bus access got no ack");
    end while (!bus_rsp.ack);
    check("err", 32'd0, bus_rsp.err);
    rd = bus_rsp.rdata;
  endtask

  ////////////////////
  // output monitor
  ////////////////////

  always @(posedge bus) begin
    if (rst_n) begin
      // evn_lst rides with the lst sample
      check("evn_lst", smp_out.vld && smp_out.lst, evn_lst);
      if (smp_out.vld) begin
        out_q.push_back(smp_out.dat);
        if (smp_out.lst) lst_cnt++;
      end
    end
  end

  initial begin
    int                   fd, n, i, k, quiet, sum, tmp;
    int                   dec, shr, avg, edg, mode, str, stp, trg, pre, pst, wave, nsmp;
    int                   act, at, e_out, e_lst, e_pre, e_pst;
    bit                   armed, fired, hi, lo;
    string                line, nm;
    logic [31:0]          pos, neg, seed, e_sts, rd, x;
    logic signed [DW-1:0] p16, n16;
    logic signed [DW-1:0] smp_q[$];
    logic signed [DW-1:0] dec_q[$];
    logic [BAW-1:0]       adr[12];
    logic [31:0]          val[12];
    bus_req = '0;
    smp_in  = '0;
    evn_ext = 2'b00;
    rst_n   = 1'b0;
    lst_cnt = 0;
    repeat (16) @(posedge bus);
    rst_n <= 1'b1;
    tname = "unmapped";
    bus_access(1'b1, 7'h7C, 32'hFFFF_FFFF, rd);
    bus_access(1'b0, 7'h7C, 32'd0, rd);
    check("readback", 32'd0, rd);
    fd = $fopen("test/scope_vectors.txt", "r");
    if (fd == 0) abort_run("cannot open the vectors file");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%s %d %d %d %d %h %h %d %d %d %d %d %d %d %d %h %d %d %d %d %d %d %h",
        nm, dec, shr, avg, edg, pos, neg, mode, str, stp, trg, pre, pst, wave, nsmp, seed,
        act, at, e_out, e_lst, e_pre, e_pst, e_sts);
      if (n != 23) abort_run("malformed line in the vectors file");
      tname = nm;
      // configuration, written then read back
      adr = '{ADR_MODE, ADR_STR, ADR_STP, ADR_TRG, ADR_PRE, ADR_PST, ADR_POS, ADR_NEG,
              ADR_EDG, ADR_DEC, ADR_SHR, ADR_AVG};
      val = '{mode, str, stp, trg, pre, pst, pos, neg, edg, dec, shr, avg};
      for (k = 0; k < 12; k++) bus_access(1'b1, adr[k], val[k], rd);
      for (k = 0; k < 12; k++) begin
        bus_access(1'b0, adr[k], 32'd0, rd);
        check("readback", val[k], rd);
      end
      // ctl reset, sw start, then one ext0 pulse as alternate start
      bus_access(1'b1, ADR_CTL, 32'd1, rd);
      bus_access(1'b1, ADR_CTL, 32'd2, rd);
      @(posedge bus);
      evn_ext <= 2'b01;
      @(posedge bus);
      evn_ext <= 2'b00;
      out_q.delete();
      lst_cnt = 0;
      // stimulus, ramps for the trigger, xorshift otherwise
      x = seed;
      smp_q.delete();
      for (i = 0; i < nsmp; i++) begin
        if (wave == 1) begin
          smp_q.push_back(-3000 + 200 * i);
        end else if (wave == 2) begin
          smp_q.push_back(3000 - 200 * i);
        end else begin
          x = xorshift(x);
          smp_q.push_back(x[DW-1:0]);
        end
      end
      // decimator model, group of dec+1
      sum = 0;
      k = 0;
      dec_q.delete();
      foreach (smp_q[j]) begin
        sum += smp_q[j];
        if (k == dec) begin
          tmp = sum >>> shr;
          dec_q.push_back(avg ? tmp[DW-1:0] : smp_q[j]);
          sum = 0;
          k = 0;
        end else begin
          k++;
        end
      end
      // trigger model on the decimated stream
      p16 = pos[DW-1:0];
      n16 = neg[DW-1:0];
      armed = 0;
      fired = 0;
      foreach (dec_q[j]) begin
        hi = dec_q[j] >= p16;
        lo = dec_q[j] <= n16;
        if (!fired && armed && (edg ? lo : hi)) fired = 1;
        else if (!fired && (edg ? hi : lo)) armed = 1;
      end
      ////////////////////
      // stream, with one event at index at
      for (i = 0; i < nsmp; i++) begin
        @(posedge bus);
        smp_in  <= '{vld: 1'b1, lst: 1'b0, dat: smp_q[i]};
        bus_req <= '0;
        evn_ext <= 2'b00;
        if (i == at && act == 1) bus_req <= '{wen: 1'b1, ren: 1'b0, addr: ADR_CTL, wdata: 8};
        if (i == at && act == 2) bus_req <= '{wen: 1'b1, ren: 1'b0, addr: ADR_CTL, wdata: 4};
        if (i == at && act == 3) evn_ext <= 2'b01;
      end
      @(posedge bus);
      smp_in  <= '0;
      bus_req <= '0;
      evn_ext <= 2'b00;
      // drain the pipeline
      quiet = 0;
      k = 0;
      while (quiet < 4) begin
        @(posedge bus);
        k++;
        quiet = smp_out.vld ? 0 : quiet + 1;
        if (k > 50) abort_run("output stream never went idle");
      end
      check("out count", e_out, out_q.size());
      check("lst count", e_lst, lst_cnt);
      for (k = 0; k < out_q.size() && k < dec_q.size(); k++) check("sample", dec_q[k], out_q[k]);
      bus_access(1'b0, ADR_STS_PRE, 32'd0, rd);
      check("cnt_pre", e_pre, rd);
      bus_access(1'b0, ADR_STS_PST, 32'd0, rd);
      check("cnt_pst", e_pst, rd);
      bus_access(1'b0, ADR_CTL, 32'd0, rd);
      check("status", e_sts, rd);
      if (trg == 2) check("edge model", fired, rd[3]);
    end
    $fclose(fd);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/scope_vectors.txt
# name dec shr avg edg pos neg mode str stp trg pre pst wave nsmp seed act at
#   exp_out exp_lst exp_pre exp_pst exp_sts (pos neg seed sts in hex, wave 0 rnd 1 up 2 down)
dec_keep 3 0 0 0 0000 0000 2 1 0 0 2 5 0 40 54c1 0 0 7 1 2 5 8
dec_avg 3 2 1 0 0000 0000 2 1 0 0 2 5 0 40 54c1 0 0 7 1 2 5 8
trg_rise 0 0 0 0 03e8 fc18 0 1 0 2 0 100 1 40 54c1 0 0 40 0 21 19 a
trg_rise_noarm 0 0 0 0 03e8 fc18 0 1 0 2 0 100 2 40 54c1 0 0 40 0 40 0 2
trg_fall 0 0 0 1 03e8 fc18 0 1 0 2 0 100 2 40 54c1 0 0 40 0 21 19 a
trg_fall_noarm 0 0 0 1 03e8 fc18 0 1 0 2 0 100 1 40 54c1 0 0 40 0 40 0 2
acq_sw 0 0 0 0 0000 0000 0 1 0 1 4 8 0 40 54c1 1 10 18 1 10 8 8
early_trg 0 0 0 0 0000 0000 0 1 0 1 8 4 0 40 54c1 1 2 40 0 40 0 2
stop_mid 0 0 0 0 0000 0000 0 1 1 0 4 100 0 40 54c1 2 10 10 0 10 0 4
cont 0 0 0 0 0000 0000 3 1 0 0 2 3 0 40 54c1 0 0 40 6 3 1 a
ext_on 0 0 0 0 0000 0000 0 4 0 4 4 8 0 40 54c1 3 10 17 1 9 8 8
ext_off 0 0 0 0 0000 0000 0 4 0 0 4 8 0 40 54c1 3 10 40 0 40 0 2

// File: build.f
hdl/scope_bus_pkg.sv
hdl/scope_stream_pkg.sv
hdl/scope_regs.sv
hdl/scope_decimator.sv
hdl/scope_trigger.sv
hdl/scope_acq.sv
hdl/scope_top.sv
test/scope_tb.sv

// File: Bender.yml
package:
  name: scope

sources:
  - hdl/scope_bus_pkg.sv
  - hdl/scope_stream_pkg.sv
  - hdl/scope_regs.sv
  - hdl/scope_decimator.sv
  - hdl/scope_trigger.sv
  - hdl/scope_acq.sv
  - hdl/scope_top.sv
  - target: test
    files:
      - test/scope_tb.sv
